// ==== rtl/cache_defines.svh ====
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 64
`define STRB_W 8

// geometry, two ways fixed in the controllers
`define SETS 64
`define WORDS_PER_LINE 4

// address split: tag | index | word | byte
`define OFFSET_LSB 3
`define OFFSET_MSB 4
`define INDEX_LSB 5
`define INDEX_MSB 10
`define TAG_LSB 11

`define MEM_WORDS 4096

`endif

// ==== rtl/cache_pkg.sv ====
`default_nettype none
`include "cache_defines.svh"

package cache_pkg;

	// controller states shared by both caches
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK, // d_cache only
		REFILL,
		RESPOND
	} cache_state_e;

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} cpu_op_e;

	typedef logic [`ADDR_W-`TAG_LSB-1:0] tag_t;
	typedef logic [`WORDS_PER_LINE*`DATA_W-1:0] line_t; // word 0 in the low bits

endpackage

`default_nettype wire

// ==== rtl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

	// who holds the memory port
	typedef enum logic {
		OWNER_I,
		OWNER_D
	} bus_owner_e;

endpackage

`default_nettype wire

// ==== rtl/axi_lite_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

interface axi_lite_if;
	logic aw_valid, aw_ready;
	logic [`ADDR_W-1:0] aw_addr;
	logic w_valid, w_ready;
	logic [`DATA_W-1:0] w_data;
	logic [`STRB_W-1:0] w_strb;
	logic b_valid, b_ready;
	bus_pkg::axi_resp_e b_resp;
	logic ar_valid, ar_ready;
	logic [`ADDR_W-1:0] ar_addr;
	logic r_valid, r_ready;
	logic [`DATA_W-1:0] r_data;
	bus_pkg::axi_resp_e r_resp;

	modport master (
		output aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready, ar_valid, ar_addr, r_ready,
		input  aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
	);

	modport slave (
		input  aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready, ar_valid, ar_addr, r_ready,
		output aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
	);
endinterface

`default_nettype wire

// ==== rtl/d_cache.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module d_cache (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       req_valid,
	input  var cache_pkg::cpu_op_e    req_op,
	input  wire [`ADDR_W-1:0]         req_addr,
	input  wire [`DATA_W-1:0]         wdata,
	input  wire [`STRB_W-1:0]         wmask,
	output logic [`DATA_W-1:0]        rdata,
	output logic                      ready,
	axi_lite_if.master                bus
);
	cache_pkg::cache_state_e state;
	cache_pkg::cpu_op_e op_q;
	logic [`ADDR_W-1:0] addr_q;
	logic [`DATA_W-1:0] wdata_q;
	logic [`STRB_W-1:0] wmask_q;

	cache_pkg::tag_t tag_mem [0:1][0:`SETS-1];
	cache_pkg::line_t data_mem [0:1][0:`SETS-1];
	logic [`SETS-1:0] valid [0:1];
	logic [`SETS-1:0] dirty [0:1];
	logic [`SETS-1:0] lru; // way to replace next

	logic [`INDEX_MSB-`INDEX_LSB:0] idx;
	logic [`OFFSET_MSB-`OFFSET_LSB:0] off, cnt;
	cache_pkg::tag_t tag;
	cache_pkg::line_t sel_line, vic_line;
	logic [`DATA_W-1:0] new_word;
	logic hit0, hit1, hit, victim, way_q;
	logic serve, serve_way, refill_beat;

	assign idx = addr_q[`INDEX_MSB:`INDEX_LSB];
	assign off = addr_q[`OFFSET_MSB:`OFFSET_LSB];
	assign tag = addr_q[`ADDR_W-1:`TAG_LSB];

	assign hit0 = valid[0][idx] && (tag_mem[0][idx] == tag);
	assign hit1 = valid[1][idx] && (tag_mem[1][idx] == tag);
	assign hit = hit0 | hit1;
	// empty way first, way 0 before way 1
	assign victim = !valid[0][idx] ? 1'b0 : (!valid[1][idx] ? 1'b1 : lru[idx]);

	assign serve = (state == cache_pkg::LOOKUP && hit) || state == cache_pkg::RESPOND;
	assign serve_way = (state == cache_pkg::RESPOND) ? way_q : hit1;
	assign refill_beat = state == cache_pkg::REFILL && bus.r_valid && bus.r_ready;

	assign sel_line = data_mem[serve_way][idx];
	assign vic_line = data_mem[way_q][idx];
	assign rdata = sel_line[off*`DATA_W +: `DATA_W];
	assign ready = serve;
	assign bus.w_strb = '1; // whole words go back to memory

	always_comb begin
		new_word = rdata;
		for (int b = 0; b < `STRB_W; b++)
			if (wmask_q[b])
				new_word[b*8 +: 8] = wdata_q[b*8 +: 8];
	end

	// storage, request latch and bus payload
	always_ff @(posedge clk) begin
		if (state == cache_pkg::IDLE && req_valid) begin
			addr_q <= req_addr;
			op_q <= req_op;
			wdata_q <= wdata;
			wmask_q <= wmask;
		end
		if (refill_beat) begin
			data_mem[way_q][idx][cnt*`DATA_W +: `DATA_W] <= bus.r_data;
			if (cnt == '1)
				tag_mem[way_q][idx] <= tag;
		end
		if (serve && op_q == cache_pkg::OP_WRITE)
			data_mem[serve_way][idx][off*`DATA_W +: `DATA_W] <= new_word;
		if (state == cache_pkg::WRITEBACK && !bus.b_ready) begin
			bus.aw_addr <= {tag_mem[way_q][idx], idx, cnt, 3'b000};
			bus.w_data <= vic_line[cnt*`DATA_W +: `DATA_W];
		end
		if (state == cache_pkg::REFILL && !bus.r_ready)
			bus.ar_addr <= {tag, idx, cnt, 3'b000};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= cache_pkg::IDLE;
			valid[0] <= '0;
			valid[1] <= '0;
			dirty[0] <= '0;
			dirty[1] <= '0;
			lru <= '0;
			way_q <= 1'b0;
			cnt <= '0;
			bus.aw_valid <= 1'b0;
			bus.w_valid <= 1'b0;
			bus.b_ready <= 1'b0;
			bus.ar_valid <= 1'b0;
			bus.r_ready <= 1'b0;
		end else begin
			case (state)
				cache_pkg::IDLE: if (req_valid) state <= cache_pkg::LOOKUP;
				cache_pkg::LOOKUP: if (!hit) begin
					way_q <= victim;
					cnt <= '0;
					if (valid[victim][idx] && dirty[victim][idx])
						state <= cache_pkg::WRITEBACK;
					else
						state <= cache_pkg::REFILL;
				end
				cache_pkg::WRITEBACK: if (!bus.b_ready) begin
					bus.aw_valid <= 1'b1; // AW and W go out together
					bus.w_valid <= 1'b1;
					bus.b_ready <= 1'b1;
				end else begin
					if (bus.aw_ready) bus.aw_valid <= 1'b0;
					if (bus.w_ready) bus.w_valid <= 1'b0;
					if (bus.b_valid) begin
						bus.b_ready <= 1'b0;
						cnt <= cnt + 1'b1;
						if (cnt == '1) state <= cache_pkg::REFILL;
					end
				end
				cache_pkg::REFILL: if (!bus.r_ready) begin
					bus.ar_valid <= 1'b1;
					bus.r_ready <= 1'b1;
				end else begin
					if (bus.ar_ready) bus.ar_valid <= 1'b0;
					if (bus.r_valid) begin
						bus.r_ready <= 1'b0;
						cnt <= cnt + 1'b1;
						if (cnt == '1) begin
							valid[way_q][idx] <= 1'b1;
							dirty[way_q][idx] <= 1'b0;
							state <= cache_pkg::RESPOND;
						end
					end
				end
				cache_pkg::RESPOND: ; // served below
				default: state <= cache_pkg::IDLE;
			endcase
			if (serve) begin
				lru[idx] <= ~serve_way;
				if (op_q == cache_pkg::OP_WRITE)
					dirty[serve_way][idx] <= 1'b1;
				state <= cache_pkg::IDLE;
			end
		end
	end
endmodule

`default_nettype wire

// ==== rtl/i_cache.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module i_cache (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire                 req_valid,
	input  wire [`ADDR_W-1:0]   req_addr,
	output logic [`DATA_W-1:0]  rdata,
	output logic                ready,
	axi_lite_if.master          bus
);
	cache_pkg::cache_state_e state;
	logic [`ADDR_W-1:0] addr_q;

	cache_pkg::tag_t tag_mem [0:1][0:`SETS-1];
	cache_pkg::line_t data_mem [0:1][0:`SETS-1];
	logic [`SETS-1:0] valid [0:1];
	logic [`SETS-1:0] lru;

	logic [`INDEX_MSB-`INDEX_LSB:0] idx;
	logic [`OFFSET_MSB-`OFFSET_LSB:0] off, cnt;
	cache_pkg::tag_t tag;
	cache_pkg::line_t sel_line;
	logic hit0, hit1, hit, way_q, serve, serve_way;

	assign idx = addr_q[`INDEX_MSB:`INDEX_LSB];
	assign off = addr_q[`OFFSET_MSB:`OFFSET_LSB];
	assign tag = addr_q[`ADDR_W-1:`TAG_LSB];
	assign hit0 = valid[0][idx] && (tag_mem[0][idx] == tag);
	assign hit1 = valid[1][idx] && (tag_mem[1][idx] == tag);
	assign hit = hit0 | hit1;
	assign serve = (state == cache_pkg::LOOKUP && hit) || state == cache_pkg::RESPOND;
	assign serve_way = (state == cache_pkg::RESPOND) ? way_q : hit1;
	assign sel_line = data_mem[serve_way][idx];
	assign rdata = sel_line[off*`DATA_W +: `DATA_W];
	assign ready = serve;

	// fetch only, write channels stay quiet
	assign bus.aw_valid = 1'b0;
	assign bus.aw_addr = '0;
	assign bus.w_valid = 1'b0;
	assign bus.w_data = '0;
	assign bus.w_strb = '0;
	assign bus.b_ready = 1'b0;

	always_ff @(posedge clk) begin
		if (state == cache_pkg::IDLE && req_valid)
			addr_q <= req_addr;
		if (state == cache_pkg::REFILL && bus.r_valid && bus.r_ready) begin
			data_mem[way_q][idx][cnt*`DATA_W +: `DATA_W] <= bus.r_data;
			if (cnt == '1) tag_mem[way_q][idx] <= tag;
		end
		if (state == cache_pkg::REFILL && !bus.r_ready)
			bus.ar_addr <= {tag, idx, cnt, 3'b000};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= cache_pkg::IDLE;
			valid[0] <= '0;
			valid[1] <= '0;
			lru <= '0;
			way_q <= 1'b0;
			cnt <= '0;
			bus.ar_valid <= 1'b0;
			bus.r_ready <= 1'b0;
		end else begin
			case (state)
				cache_pkg::IDLE: if (req_valid) state <= cache_pkg::LOOKUP;
				cache_pkg::LOOKUP: if (!hit) begin
					way_q <= !valid[0][idx] ? 1'b0 : (!valid[1][idx] ? 1'b1 : lru[idx]);
					cnt <= '0;
					state <= cache_pkg::REFILL;
				end
				cache_pkg::REFILL: if (!bus.r_ready) begin
					bus.ar_valid <= 1'b1;
					bus.r_ready <= 1'b1;
				end else begin
					if (bus.ar_ready) bus.ar_valid <= 1'b0;
					if (bus.r_valid) begin
						bus.r_ready <= 1'b0;
						cnt <= cnt + 1'b1;
						if (cnt == '1) begin
							valid[way_q][idx] <= 1'b1;
							state <= cache_pkg::RESPOND;
						end
					end
				end
				cache_pkg::RESPOND: ;
				default: state <= cache_pkg::IDLE; // no write-back here
			endcase
			if (serve) begin
				lru[idx] <= ~serve_way;
				state <= cache_pkg::IDLE;
			end
		end
	end
endmodule

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input wire          clk,
	input wire          rst_n,
	axi_lite_if.slave   i_bus,
	axi_lite_if.slave   d_bus,
	axi_lite_if.master  mem_bus
);
	bus_pkg::bus_owner_e owner, last, grant;
	logic busy, req_i, req_d, sel_d, done;

	assign req_i = i_bus.ar_valid | i_bus.aw_valid;
	assign req_d = d_bus.ar_valid | d_bus.aw_valid;
	assign done = (mem_bus.r_valid && mem_bus.r_ready) || (mem_bus.b_valid && mem_bus.b_ready);

	always_comb begin
		if (busy)
			grant = owner;
		else if (req_i && req_d) // tie goes to the one not served last
			grant = (last == bus_pkg::OWNER_I) ? bus_pkg::OWNER_D : bus_pkg::OWNER_I;
		else if (req_d)
			grant = bus_pkg::OWNER_D;
		else
			grant = bus_pkg::OWNER_I;
	end
	assign sel_d = (grant == bus_pkg::OWNER_D);

	assign mem_bus.aw_valid = sel_d ? d_bus.aw_valid : i_bus.aw_valid;
	assign mem_bus.aw_addr = sel_d ? d_bus.aw_addr : i_bus.aw_addr;
	assign mem_bus.w_valid = sel_d ? d_bus.w_valid : i_bus.w_valid;
	assign mem_bus.w_data = sel_d ? d_bus.w_data : i_bus.w_data;
	assign mem_bus.w_strb = sel_d ? d_bus.w_strb : i_bus.w_strb;
	assign mem_bus.b_ready = sel_d ? d_bus.b_ready : i_bus.b_ready;
	assign mem_bus.ar_valid = sel_d ? d_bus.ar_valid : i_bus.ar_valid;
	assign mem_bus.ar_addr = sel_d ? d_bus.ar_addr : i_bus.ar_addr;
	assign mem_bus.r_ready = sel_d ? d_bus.r_ready : i_bus.r_ready;

	// handshakes only reach the owner
	assign i_bus.aw_ready = !sel_d && mem_bus.aw_ready;
	assign i_bus.w_ready = !sel_d && mem_bus.w_ready;
	assign i_bus.b_valid = !sel_d && mem_bus.b_valid;
	assign i_bus.ar_ready = !sel_d && mem_bus.ar_ready;
	assign i_bus.r_valid = !sel_d && mem_bus.r_valid;
	assign d_bus.aw_ready = sel_d && mem_bus.aw_ready;
	assign d_bus.w_ready = sel_d && mem_bus.w_ready;
	assign d_bus.b_valid = sel_d && mem_bus.b_valid;
	assign d_bus.ar_ready = sel_d && mem_bus.ar_ready;
	assign d_bus.r_valid = sel_d && mem_bus.r_valid;

	assign i_bus.r_data = mem_bus.r_data;
	assign i_bus.r_resp = mem_bus.r_resp;
	assign i_bus.b_resp = mem_bus.b_resp;
	assign d_bus.r_data = mem_bus.r_data;
	assign d_bus.r_resp = mem_bus.r_resp;
	assign d_bus.b_resp = mem_bus.b_resp;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			owner <= bus_pkg::OWNER_I;
			last <= bus_pkg::OWNER_I;
		end else if (!busy && (req_i || req_d)) begin
			busy <= 1'b1;
			owner <= grant;
		end else if (busy && done) begin // R or B taken, release
			busy <= 1'b0;
			last <= owner;
		end
	end
endmodule

`default_nettype wire

// ==== rtl/backing_mem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module backing_mem (
	input wire         clk,
	input wire         rst_n,
	axi_lite_if.slave  bus
);
	localparam int IDX_W = $clog2(`MEM_WORDS);

	logic [`DATA_W-1:0] mem [0:`MEM_WORDS-1];
	logic [IDX_W-1:0] rd_idx, wr_idx;
	logic wr_go;

	initial begin
		for (int i = 0; i < `MEM_WORDS; i++)
			mem[i] = '0;
	end

	assign rd_idx = bus.ar_addr[IDX_W+2:3]; // word address
	assign wr_idx = bus.aw_addr[IDX_W+2:3];
	assign wr_go = bus.aw_valid && bus.w_valid && !bus.b_valid;

	assign bus.ar_ready = !bus.r_valid; // one read in flight
	assign bus.aw_ready = wr_go;
	assign bus.w_ready = wr_go;
	assign bus.r_resp = bus_pkg::OKAY;
	assign bus.b_resp = bus_pkg::OKAY;

	always @(posedge clk) begin
		if (wr_go)
			for (int b = 0; b < `STRB_W; b++)
				if (bus.w_strb[b])
					mem[wr_idx][b*8 +: 8] <= bus.w_data[b*8 +: 8];
	end

	always_ff @(posedge clk) begin
		if (bus.ar_valid && bus.ar_ready)
			bus.r_data <= mem[rd_idx];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bus.r_valid <= 1'b0;
			bus.b_valid <= 1'b0;
		end else begin
			if (bus.ar_valid && bus.ar_ready) bus.r_valid <= 1'b1;
			else if (bus.r_ready) bus.r_valid <= 1'b0;
			if (wr_go) bus.b_valid <= 1'b1;
			else if (bus.b_ready) bus.b_valid <= 1'b0;
		end
	end
endmodule

`default_nettype wire

// ==== rtl/cache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module cache_subsystem (
	input  wire                      clk,
	input  wire                      rst_n,
	// data port
	input  wire                      d_req_valid,
	input  var cache_pkg::cpu_op_e   d_req_op,
	input  wire [`ADDR_W-1:0]        d_req_addr,
	input  wire [`DATA_W-1:0]        d_wdata,
	input  wire [`STRB_W-1:0]        d_wmask,
	output logic [`DATA_W-1:0]       d_rdata,
	output logic                     d_ready,
	// fetch port
	input  wire                      i_req_valid,
	input  wire [`ADDR_W-1:0]        i_req_addr,
	output logic [`DATA_W-1:0]       i_rdata,
	output logic                     i_ready
);
	axi_lite_if i_bus ();
	axi_lite_if d_bus ();
	axi_lite_if m_bus (); // shared side, after the arbiter

	i_cache u_i_cache (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (i_req_valid),
		.req_addr  (i_req_addr),
		.rdata     (i_rdata),
		.ready     (i_ready),
		.bus       (i_bus)
	);

	d_cache u_d_cache (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (d_req_valid),
		.req_op    (d_req_op),
		.req_addr  (d_req_addr),
		.wdata     (d_wdata),
		.wmask     (d_wmask),
		.rdata     (d_rdata),
		.ready     (d_ready),
		.bus       (d_bus)
	);

	mem_arbiter u_arbiter (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_bus   (i_bus),
		.d_bus   (d_bus),
		.mem_bus (m_bus)
	);

	backing_mem u_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (m_bus)
	);
endmodule

`default_nettype wire

// ==== sim/cache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module cache_checker (
	input wire                clk,
	input wire                d_ready,
	input wire [`DATA_W-1:0]  d_rdata,
	input wire                i_ready,
	input wire [`DATA_W-1:0]  i_rdata
);
	logic [`DATA_W:0] d_pending [$]; // top bit set when rdata counts
	logic [`DATA_W-1:0] i_pending [$];
	logic [`DATA_W:0] d_head;
	logic [`DATA_W-1:0] i_head;
	int mismatches = 0;
	int other_errors = 0;

	function automatic void add_expected(input bit is_d, input bit check_data,
			input logic [`DATA_W-1:0] value);
		if (is_d)
			d_pending.push_back({check_data, value});
		else
			i_pending.push_back(value);
	endfunction

	// sample mid-cycle when outputs are settled
	always @(negedge clk) begin
		if (d_ready) begin
			if (d_pending.size() == 0) begin
				$display("%0t: d_ready pulsed with no data request pending", $time);
				other_errors++;
			end else begin
				d_head = d_pending.pop_front();
				if (d_head[`DATA_W] && d_rdata !== d_head[`DATA_W-1:0]) begin
					$display("MISMATCH %0t d_rdata expected %h got %h",
						$time, d_head[`DATA_W-1:0], d_rdata);
					mismatches++;
				end
			end
		end
		if (i_ready) begin
			if (i_pending.size() == 0) begin
				$display("%0t: i_ready pulsed with no fetch pending", $time);
				other_errors++;
			end else begin
				i_head = i_pending.pop_front();
				if (i_rdata !== i_head) begin
					$display("MISMATCH %0t i_rdata expected %h got %h", $time, i_head, i_rdata);
					mismatches++;
				end
			end
		end
	end
endmodule

`default_nettype wire

// ==== sim/tb_cache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module tb_cache_subsystem;
	logic clk = 1'b0;
	logic rst_n;
	logic d_req_valid;
	cache_pkg::cpu_op_e d_req_op;
	logic [`ADDR_W-1:0] d_req_addr;
	logic [`DATA_W-1:0] d_wdata;
	logic [`STRB_W-1:0] d_wmask;
	wire [`DATA_W-1:0] d_rdata;
	wire d_ready;
	logic i_req_valid;
	logic [`ADDR_W-1:0] i_req_addr;
	wire [`DATA_W-1:0] i_rdata;
	wire i_ready;

	// one entry per case line
	int ph_q [$];
	logic [7:0] port_q [$];
	logic [7:0] op_q [$];
	logic [`ADDR_W-1:0] addr_q [$];
	logic [`DATA_W-1:0] wdata_q [$];
	logic [`STRB_W-1:0] mask_q [$];
	logic [`DATA_W-1:0] exp_q [$];
	int gap_q [$];
	int last_phase = 0;
	int d_phase_done = 0;
	int i_phase_done = 0;
	int setup_errors = 0;
	int cycles = 0;
	int limit = 0;
	int errors;

	always #2 clk = ~clk;

	cache_subsystem dut_i (
		.clk(clk), .rst_n(rst_n),
		.d_req_valid(d_req_valid), .d_req_op(d_req_op), .d_req_addr(d_req_addr),
		.d_wdata(d_wdata), .d_wmask(d_wmask), .d_rdata(d_rdata), .d_ready(d_ready),
		.i_req_valid(i_req_valid), .i_req_addr(i_req_addr),
		.i_rdata(i_rdata), .i_ready(i_ready)
	);

	cache_checker chk (
		.clk(clk), .d_ready(d_ready), .d_rdata(d_rdata), .i_ready(i_ready), .i_rdata(i_rdata)
	);

	task automatic read_cases();
		int fd, n, ph;
		logic [7:0] p, o;
		logic [`ADDR_W-1:0] a;
		logic [`DATA_W-1:0] wd, ex;
		logic [`STRB_W-1:0] m;
		logic [8*160-1:0] line;
		fd = $fopen("sim/cache_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/cache_cases.txt");
			setup_errors++;
		end else begin
			line = '0;
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%d %s %s %h %h %h %h", ph, p, o, a, wd, m, ex);
				if (n == 7) begin // comment and blank lines fall through
					if (p != "D" && p != "I") begin
						$display("case line with unknown port %s", p);
						setup_errors++;
					end
					ph_q.push_back(ph);
					port_q.push_back(p);
					op_q.push_back(o);
					addr_q.push_back(a);
					wdata_q.push_back(wd);
					mask_q.push_back(m);
					exp_q.push_back(ex);
					if (ph > last_phase)
						last_phase = ph;
				end
				line = '0;
			end
			$fclose(fd);
		end
	endtask

	task automatic idle_for(input bit is_d, input int n);
		@(posedge clk);
		if (is_d)
			d_req_valid <= 1'b0;
		else
			i_req_valid <= 1'b0;
		repeat (n - 1) @(posedge clk);
	endtask

	// present one case and hold it until ready
	task automatic issue(input int k);
		@(posedge clk);
		if (port_q[k] == "D") begin
			d_req_valid <= 1'b1;
			d_req_op <= (op_q[k] == "W") ? cache_pkg::OP_WRITE : cache_pkg::OP_READ;
			d_req_addr <= addr_q[k];
			d_wdata <= wdata_q[k];
			d_wmask <= mask_q[k];
			chk.add_expected(1'b1, op_q[k] != "W", exp_q[k]);
			do @(negedge clk); while (!d_ready);
		end else begin
			i_req_valid <= 1'b1;
			i_req_addr <= addr_q[k];
			chk.add_expected(1'b0, 1'b1, exp_q[k]);
			do @(negedge clk); while (!i_ready);
		end
	endtask

	task automatic run_port(input bit is_d);
		int first;
		for (int p = 0; p <= last_phase; p++) begin
			first = 1;
			for (int k = 0; k < ph_q.size(); k++) begin
				if (ph_q[k] == p && (port_q[k] == "D") == is_d) begin
					if (!first && gap_q[k] > 0)
						idle_for(is_d, gap_q[k]);
					issue(k);
					first = 0;
				end
			end
			idle_for(is_d, 1);
			if (is_d)
				d_phase_done = p + 1;
			else
				i_phase_done = p + 1;
			while (d_phase_done <= p || i_phase_done <= p)
				@(d_phase_done or i_phase_done); // both ports enter the next phase together
		end
	endtask

	initial begin
		rst_n = 1'b0;
		d_req_valid = 1'b0;
		d_req_op = cache_pkg::OP_READ;
		d_req_addr = '0;
		d_wdata = '0;
		d_wmask = '0;
		i_req_valid = 1'b0;
		i_req_addr = '0;
		void'($urandom(32'h5d238004));
		read_cases();
		for (int k = 0; k < ph_q.size(); k++)
			gap_q.push_back($urandom % 4);
		limit = 400 * ph_q.size() + 20;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		fork
			run_port(1'b1);
			run_port(1'b0);
		join
		repeat (4) @(posedge clk);
		errors = chk.mismatches + chk.other_errors + setup_errors;
		$display("mismatches: %0d, other errors: %0d",
			chk.mismatches, chk.other_errors + setup_errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles == limit) begin
			$display("timeout after %0d cycles, a request never got its ready", cycles);
			$display("mismatches: %0d, other errors: %0d",
				chk.mismatches, chk.other_errors + setup_errors + 1);
			$display("*** FAILED ***");
			$finish;
		end
	end
endmodule

`default_nettype wire

// ==== cache_subsystem.f ====
+incdir+rtl
rtl/cache_pkg.sv
rtl/bus_pkg.sv
rtl/axi_lite_if.sv
rtl/d_cache.sv
rtl/i_cache.sv
rtl/mem_arbiter.sv
rtl/backing_mem.sv
rtl/cache_subsystem.sv
sim/cache_checker.sv
sim/tb_cache_subsystem.sv

// ==== Bender.yml ====
package:
  name: cache_subsystem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cache_pkg.sv
      - rtl/bus_pkg.sv
      - rtl/axi_lite_if.sv
      - rtl/d_cache.sv
      - rtl/i_cache.sv
      - rtl/mem_arbiter.sv
      - rtl/backing_mem.sv
      - rtl/cache_subsystem.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/cache_checker.sv
      - sim/tb_cache_subsystem.sv

// ==== sim/cache_cases.txt ====
# phase port op address wdata mask expected
# the first D and I cases of a phase start on the same cycle
0 D R 00000100 0000000000000000 00 0000000000000000
0 D W 00000100 1122334455667788 ff 0000000000000000
0 D R 00000100 0000000000000000 00 1122334455667788
0 D W 00000108 aaaaaaaaaaaaaaaa 0f 0000000000000000
0 D W 00000108 bbbbbbbbbbbbbbbb f0 0000000000000000
0 D R 00000108 0000000000000000 00 bbbbbbbbaaaaaaaa
0 D W 00000110 0102030405060708 ff 0000000000000000
0 D W 00000110 ffffffffffffffff 81 0000000000000000
0 D R 00000110 0000000000000000 00 ff020304050607ff
1 D W 00000900 0900090009000900 ff 0000000000000000
1 D W 00001100 1100110011001100 ff 0000000000000000
1 D R 00000100 0000000000000000 00 1122334455667788
1 D R 00000110 0000000000000000 00 ff020304050607ff
1 D R 00000900 0000000000000000 00 0900090009000900
2 I R 00001100 0000000000000000 00 1100110011001100
2 I R 00000108 0000000000000000 00 bbbbbbbbaaaaaaaa
2 I R 00004000 0000000000000000 00 0000000000000000
2 I R 00001108 0000000000000000 00 0000000000000000
3 D R 00001100 0000000000000000 00 1100110011001100
3 I R 00000900 0000000000000000 00 0900090009000900
3 D W 00002000 deadbeefcafef00d ff 0000000000000000
3 I R 00000110 0000000000000000 00 ff020304050607ff
3 I R 00003000 0000000000000000 00 0000000000000000
4 D R 00002000 0000000000000000 00 deadbeefcafef00d
4 D W 00002008 123456789abcdef0 3c 0000000000000000
4 D R 00002008 0000000000000000 00 000056789abc0000
4 D R 00004000 0000000000000000 00 0000000000000000
4 D R 00006000 0000000000000000 00 0000000000000000
4 D R 00002008 0000000000000000 00 000056789abc0000
4 D R 00002000 0000000000000000 00 deadbeefcafef00d
4 I R 00000900 0000000000000000 00 0900090009000900
4 I R 00001100 0000000000000000 00 1100110011001100
4 I R 00000118 0000000000000000 00 0000000000000000
